// File: dcachePkg.sv
`default_nettype none

package dcachePkg;

   localparam int wordWidth  = 32;
   localparam int tagWidth   = 26;
   localparam int indexWidth = 3;
   localparam int numSets    = 8;
   localparam int byteBits   = 2;

   typedef logic [wordWidth-1:0]  word_t;
   typedef logic [tagWidth-1:0]   tag_t;
   typedef logic [indexWidth-1:0] index_t;
   typedef logic [1:0][wordWidth-1:0] block_t;   // [1] is the upper word

   typedef enum logic [3:0] {
      idle,
      wbWord0,
      wbWord1,         // victim write-back
      fillWord0,
      fillWord1,       // read miss fill
      mergeFetch,      // write miss, other word from memory
      install,
      writeHit,
      respond,
      flushWay0Word0,
      flushWay0Word1,
      flushWay1Word0,
      flushWay1Word1,
      flushNext,
      flushed
   } cacheState_t;

endpackage

`default_nettype wire

// File: dcacheLookup.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheLookup
   import dcachePkg::*;
(
   input  word_t       dmemaddr,
   input  logic        dmemREN,
   input  logic        dmemWEN,
   input  cacheState_t state,
   input  tag_t        tag0,
   input  tag_t        tag1,
   input  logic        valid0,
   input  logic        valid1,
   input  logic        dirty0,
   input  logic        dirty1,
   input  logic        lruWay1,
   input  block_t      data0,
   input  block_t      data1,
   output logic        dhit,
   output word_t       dmemload,
   output logic        hit,
   output logic        hitWay,
   output logic        victimWay,
   output logic        victimDirty
);

   tag_t   addrTag;
   logic   offset;
   logic   match0;
   logic   match1;
   block_t hitBlock;

   assign addrTag = dmemaddr[wordWidth-1 -: tagWidth];
   assign offset  = dmemaddr[byteBits];

   assign match0 = valid0 && (tag0 == addrTag);
   assign match1 = valid1 && (tag1 == addrTag);
   assign hit    = match0 || match1;
   assign hitWay = !match0;                      // way 0 wins if both match

   assign victimWay   = lruWay1;                 // lru bit names the victim
   assign victimDirty = lruWay1 ? dirty1 : dirty0;

   always_comb
   begin
      hitBlock = match0 ? data0 : data1;
      // writes only finish once the FSM reaches respond
      dhit     = (dmemREN && hit) || (dmemWEN && hit && state == respond);
      dmemload = (dmemREN && hit) ? hitBlock[offset] : '0;
   end

endmodule

`default_nettype wire

// File: dcacheStore.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheStore
   import dcachePkg::*;
(
   input  logic   CLK,
   input  logic   nRST,
   input  index_t index,
   input  index_t cleanIndex,
   input  logic   fillEn,
   input  logic   fillWay,
   input  logic   fillHalf,
   input  word_t  fillData,
   input  logic   installEn,
   input  logic   installWay,
   input  tag_t   installTag,
   input  logic   installDirty,
   input  logic   markDirtyEn,
   input  logic   markDirtyWay,
   input  logic   cleanEn,
   input  logic   cleanWay,
   input  logic   touchEn,
   input  logic   touchWay,
   output tag_t   tag0,
   output tag_t   tag1,
   output logic   valid0,
   output logic   valid1,
   output logic   dirty0,
   output logic   dirty1,
   output logic   lruWay1,
   output block_t data0,
   output block_t data1,
   output tag_t   cleanTag0,
   output tag_t   cleanTag1,
   output logic   cleanDirty0,
   output logic   cleanDirty1,
   output block_t cleanData0,
   output block_t cleanData1
);

   tag_t   tagArr  [2][numSets];
   block_t dataArr [2][numSets];
   logic [1:0][numSets-1:0] validArr;
   logic [1:0][numSets-1:0] dirtyArr;
   logic [numSets-1:0]      lruArr;              // 1 means way 1 is next out

   always_ff @(posedge CLK)
   begin
      if (fillEn)
         dataArr[fillWay][index][fillHalf] <= fillData;
      if (installEn)
         tagArr[installWay][index] <= installTag;
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         validArr <= '0;
         dirtyArr <= '0;
         lruArr   <= '0;
      end
      else
      begin
         if (installEn)
         begin
            validArr[installWay][index] <= 1'b1;
            dirtyArr[installWay][index] <= installDirty;
         end
         if (markDirtyEn)
            dirtyArr[markDirtyWay][index] <= 1'b1;
         if (cleanEn)
            dirtyArr[cleanWay][cleanIndex] <= 1'b0;   // block now matches memory
         if (touchEn)
            lruArr[index] <= ~touchWay;
      end
   end

   assign tag0    = tagArr[0][index];
   assign tag1    = tagArr[1][index];
   assign valid0  = validArr[0][index];
   assign valid1  = validArr[1][index];
   assign dirty0  = dirtyArr[0][index];
   assign dirty1  = dirtyArr[1][index];
   assign lruWay1 = lruArr[index];
   assign data0   = dataArr[0][index];
   assign data1   = dataArr[1][index];

   // write-back view, follows the flush counter during halt
   assign cleanTag0   = tagArr[0][cleanIndex];
   assign cleanTag1   = tagArr[1][cleanIndex];
   assign cleanDirty0 = dirtyArr[0][cleanIndex];
   assign cleanDirty1 = dirtyArr[1][cleanIndex];
   assign cleanData0  = dataArr[0][cleanIndex];
   assign cleanData1  = dataArr[1][cleanIndex];

endmodule

`default_nettype wire

// File: dcacheControl.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheControl
   import dcachePkg::*;
(
   input  logic        CLK,
   input  logic        nRST,
   input  logic        dmemREN,
   input  logic        dmemWEN,
   input  logic        halt,
   input  word_t       dmemaddr,
   input  word_t       dmemstore,
   input  logic        hit,
   input  logic        hitWay,
   input  logic        victimWay,
   input  logic        victimDirty,
   input  logic        dwait,
   input  word_t       dload,
   input  tag_t        cleanTag0,
   input  tag_t        cleanTag1,
   input  logic        cleanDirty0,
   input  logic        cleanDirty1,
   input  block_t      cleanData0,
   input  block_t      cleanData1,
   output cacheState_t state,
   output logic        fillEn,
   output logic        fillWay,
   output logic        fillHalf,
   output word_t       fillData,
   output logic        installEn,
   output logic        installWay,
   output tag_t        installTag,
   output logic        installDirty,
   output logic        markDirtyEn,
   output logic        markDirtyWay,
   output logic        cleanEn,
   output logic        cleanWay,
   output logic        touchEn,
   output logic        touchWay,
   output logic        dREN,
   output logic        dWEN,
   output word_t       daddr,
   output word_t       dstore,
   output logic        flushed,
   output index_t      cleanIndex
);

   cacheState_t nextState;
   index_t      flushSet;
   index_t      addrIndex;
   tag_t        addrTag;
   logic        offset;
   logic        wbState;
   logic        wbWay;
   logic        wbHalf;
   logic        wbDirty;
   logic        fetchHalf;
   tag_t        wbTag;
   block_t      wbBlock;

   assign addrTag   = dmemaddr[wordWidth-1 -: tagWidth];
   assign addrIndex = dmemaddr[byteBits+1 +: indexWidth];
   assign offset    = dmemaddr[byteBits];

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state    <= idle;
         flushSet <= '0;
      end
      else
      begin
         state <= nextState;
         if (state == flushNext)
            flushSet <= flushSet + 1'b1;
      end
   end

   // which way and word a write-back state sends
   always_comb
   begin
      wbState   = 1'b1;
      wbWay     = victimWay;
      wbHalf    = 1'b0;
      fetchHalf = 1'b0;
      case (state)
         wbWord0: ;
         wbWord1: wbHalf = 1'b1;
         flushWay0Word0: wbWay = 1'b0;
         flushWay0Word1:
         begin
            wbWay  = 1'b0;
            wbHalf = 1'b1;
         end
         flushWay1Word0: wbWay = 1'b1;
         flushWay1Word1:
         begin
            wbWay  = 1'b1;
            wbHalf = 1'b1;
         end
         default:
         begin
            wbState   = 1'b0;
            fetchHalf = (state == fillWord1) || (state == mergeFetch && !offset);
         end
      endcase
   end

   assign wbTag      = wbWay ? cleanTag1 : cleanTag0;
   assign wbBlock    = wbWay ? cleanData1 : cleanData0;
   assign wbDirty    = wbWay ? cleanDirty1 : cleanDirty0;
   assign cleanIndex = (state == wbWord0 || state == wbWord1) ? addrIndex : flushSet;

   assign dWEN    = wbState && wbDirty;            // clean flush blocks are skipped
   assign dREN    = (state == fillWord0) || (state == fillWord1) || (state == mergeFetch);
   assign dstore  = wbBlock[wbHalf];
   assign daddr   = wbState ? {wbTag, cleanIndex, wbHalf, {byteBits{1'b0}}}
                            : {addrTag, addrIndex, fetchHalf, {byteBits{1'b0}}};
   assign flushed = (state == dcachePkg::flushed);

   assign installWay   = victimWay;
   assign installTag   = addrTag;
   assign installDirty = dmemWEN;
   assign markDirtyWay = hitWay;
   assign cleanWay     = wbWay;

   always_comb
   begin
      nextState   = state;
      fillEn      = 1'b0;
      fillWay     = victimWay;
      fillHalf    = fetchHalf;
      fillData    = dload;
      installEn   = 1'b0;
      markDirtyEn = 1'b0;
      cleanEn     = 1'b0;
      touchEn     = 1'b0;
      touchWay    = hitWay;
      case (state)
         idle:
         begin
            if (dmemREN && hit)
               touchEn = 1'b1;                    // read hit served combinationally
            else if (dmemWEN && hit)
               nextState = writeHit;
            else if (dmemREN || dmemWEN)
               nextState = victimDirty ? wbWord0 : (dmemREN ? fillWord0 : mergeFetch);
            else if (halt)
               nextState = flushWay0Word0;
         end
         wbWord0:
            if (!dwait)
               nextState = wbWord1;
         wbWord1:
            if (!dwait)
            begin
               cleanEn   = 1'b1;
               nextState = dmemREN ? fillWord0 : mergeFetch;
            end
         fillWord0, fillWord1, mergeFetch:
            if (!dwait)
            begin
               fillEn    = 1'b1;
               nextState = (state == fillWord0) ? fillWord1 : install;
            end
         install:
         begin
            installEn = 1'b1;
            touchEn   = 1'b1;
            touchWay  = victimWay;
            if (dmemWEN)
            begin
               fillEn   = 1'b1;                   // merge the stored word
               fillHalf = offset;
               fillData = dmemstore;
            end
            nextState = respond;
         end
         writeHit:
         begin
            fillEn      = 1'b1;
            fillWay     = hitWay;
            fillHalf    = offset;
            fillData    = dmemstore;
            markDirtyEn = 1'b1;
            touchEn     = 1'b1;
            nextState   = respond;
         end
         respond: nextState = idle;
         flushWay0Word0:
            if (!cleanDirty0)
               nextState = flushWay1Word0;
            else if (!dwait)
               nextState = flushWay0Word1;
         flushWay0Word1:
            if (!dwait)
            begin
               cleanEn   = 1'b1;
               nextState = flushWay1Word0;
            end
         flushWay1Word0:
            if (!cleanDirty1)
               nextState = flushNext;
            else if (!dwait)
               nextState = flushWay1Word1;
         flushWay1Word1:
            if (!dwait)
            begin
               cleanEn   = 1'b1;
               nextState = flushNext;
            end
         flushNext:
            nextState = (flushSet == index_t'(numSets - 1)) ? dcachePkg::flushed
                                                            : flushWay0Word0;
         default: ;                               // flushed holds until reset
      endcase
   end

   // install must have made the block resident
   assert property (@(posedge CLK) disable iff (!nRST) (state == respond) |-> hit)
      else $error("respond reached without a resident block");

   assert property (@(posedge CLK) disable iff (!nRST) installEn |-> !hit)
      else $error("install of a block that is already resident");

   // memory transfer must not move under back-pressure
   assert property (@(posedge CLK) disable iff (!nRST)
      ((dREN || dWEN) && dwait) |=> ($stable(daddr) && $stable(dstore)))
      else $error("memory request changed while dwait high");

endmodule

`default_nettype wire

// File: dcache.sv
`timescale 1ns/1ps
`default_nettype none

module dcache
   import dcachePkg::*;
(
   input  logic  CLK,
   input  logic  nRST,
   input  logic  dmemREN,
   input  logic  dmemWEN,
   input  word_t dmemaddr,
   input  word_t dmemstore,
   input  logic  halt,
   output logic  dhit,
   output word_t dmemload,
   output logic  flushed,
   output logic  dREN,
   output logic  dWEN,
   output word_t daddr,
   output word_t dstore,
   input  logic  dwait,
   input  word_t dload
);

   cacheState_t state;
   logic        hit, hitWay, victimWay, victimDirty;
   tag_t        tag0, tag1, cleanTag0, cleanTag1, installTag;
   logic        valid0, valid1, dirty0, dirty1, lruWay1;
   logic        cleanDirty0, cleanDirty1;
   block_t      data0, data1, cleanData0, cleanData1;
   index_t      cleanIndex;
   word_t       fillData;
   logic        fillEn, fillWay, fillHalf;
   logic        installEn, installWay, installDirty;
   logic        markDirtyEn, markDirtyWay;
   logic        cleanEn, cleanWay, touchEn, touchWay;

   dcacheLookup i_lookup (
      .dmemaddr, .dmemREN, .dmemWEN, .state,
      .tag0, .tag1, .valid0, .valid1, .dirty0, .dirty1, .lruWay1,
      .data0, .data1,
      .dhit, .dmemload, .hit, .hitWay, .victimWay, .victimDirty
   );

   dcacheStore i_store (
      .CLK, .nRST,
      .index(dmemaddr[byteBits+1 +: indexWidth]), .cleanIndex,
      .fillEn, .fillWay, .fillHalf, .fillData,
      .installEn, .installWay, .installTag, .installDirty,
      .markDirtyEn, .markDirtyWay, .cleanEn, .cleanWay, .touchEn, .touchWay,
      .tag0, .tag1, .valid0, .valid1, .dirty0, .dirty1, .lruWay1, .data0, .data1,
      .cleanTag0, .cleanTag1, .cleanDirty0, .cleanDirty1, .cleanData0, .cleanData1
   );

   dcacheControl i_control (
      .CLK, .nRST, .dmemREN, .dmemWEN, .halt, .dmemaddr, .dmemstore,
      .hit, .hitWay, .victimWay, .victimDirty, .dwait, .dload,
      .cleanTag0, .cleanTag1, .cleanDirty0, .cleanDirty1, .cleanData0, .cleanData1,
      .state, .fillEn, .fillWay, .fillHalf, .fillData,
      .installEn, .installWay, .installTag, .installDirty,
      .markDirtyEn, .markDirtyWay, .cleanEn, .cleanWay, .touchEn, .touchWay,
      .dREN, .dWEN, .daddr, .dstore, .flushed, .cleanIndex
   );

endmodule

`default_nettype wire

// File: dcacheMemModel.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheMemModel
   import dcachePkg::*;
#(
   parameter word_t fillKey = '0
)
(
   input  logic       CLK,
   input  logic       nRST,
   input  logic [1:0] latency,
   input  logic       dREN,
   input  logic       dWEN,
   input  word_t      daddr,
   input  word_t      dstore,
   output logic       dwait,
   output word_t      dload
);

   word_t      mem [256];
   logic       busy;
   logic       started;                         // wait count latched for this word
   logic [1:0] count;

   initial
   begin
      for (int i = 0; i < 256; i++)
         mem[i] = word_t'(i << 2) ^ fillKey;    // pattern over the whole address
   end

   assign busy  = dREN || dWEN;
   assign dwait = busy && (started ? (count != 2'd0) : (latency != 2'd0));
   assign dload = mem[daddr[9:2]];

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         started <= 1'b0;
         count   <= 2'd0;
      end
      else if (dwait)
      begin
         started <= 1'b1;
         count   <= (started ? count : latency) - 2'd1;
      end
      else
         started <= 1'b0;                       // next word draws a new latency
   end

   always @(posedge CLK)
   begin
      if (dWEN && !dwait)
         mem[daddr[9:2]] <= dstore;
   end

endmodule

`default_nettype wire

// File: dcacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module dcacheTb
   import dcachePkg::*;
;

   localparam int    halfPeriod  = 10;
   localparam int    driveDelay  = 2;
   localparam int    directedOps = 9;
   localparam int    randomOps   = 300;
   localparam int    flushOps    = numSets;   // one set walk step counted as one op
   localparam int    cycleLimit  = 40 * (directedOps + randomOps + flushOps);
   localparam word_t fillKey     = 32'h5a3c96e1;

   logic        CLK;
   logic        nRST;
   logic        dmemREN;
   logic        dmemWEN;
   logic        halt;
   logic        dhit;
   logic        flushed;
   logic        dREN;
   logic        dWEN;
   logic        dwait;
   logic        rehit;                        // write to the previous op's address
   logic [1:0]  latency;
   logic [31:0] stimState;
   logic [31:0] waitState;
   logic [31:0] waitBits;
   word_t       dmemaddr;
   word_t       dmemstore;
   word_t       dmemload;
   word_t       daddr;
   word_t       dstore;
   word_t       dload;
   word_t       shadow [64];
   int          writeAge;
   int          cycleCount;

   dcache i_dcache (
      .CLK, .nRST, .dmemREN, .dmemWEN, .dmemaddr, .dmemstore, .halt,
      .dhit, .dmemload, .flushed, .dREN, .dWEN, .daddr, .dstore, .dwait, .dload
   );

   dcacheMemModel #(.fillKey(fillKey)) i_mem (
      .CLK, .nRST, .latency, .dREN, .dWEN, .daddr, .dstore, .dwait, .dload
   );

   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
   endfunction

   task automatic takeBits(inout logic [31:0] state, input int count, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < count; i++)
      begin
         state = lfsrStep(state);
         value = {value[30:0], state[0]};
      end
   endtask

   function automatic word_t addrOf(input int tag, input int set, input int word);
      return {24'b0, 2'(tag), 3'(set), 1'(word), 2'b00};
   endfunction

   task automatic abortRun();
      $display("** FAIL **");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic reportError(input string msg);
      $display("Error: %0t ns %s", $time, msg);
      abortRun();
   endtask

   // one request, held until dhit, then one idle cycle
   task automatic runOp(input logic write, input word_t addr, input word_t data, input logic again);
      dmemaddr  = addr;
      dmemstore = data;
      dmemREN   = !write;
      dmemWEN   = write;
      rehit     = again;
      if (write)
         shadow[addr[7:2]] = data;
      do
         @(negedge CLK);
      while (!dhit);
      @(posedge CLK);
      #driveDelay;
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
      rehit   = 1'b0;
      @(posedge CLK);
      #driveDelay;
   endtask

   always #halfPeriod CLK = ~CLK;

   always @(posedge CLK)
   begin
      #driveDelay;
      takeBits(waitState, 2, waitBits);
      latency = waitBits[1:0];
   end

   always @(posedge CLK)
      writeAge <= dmemWEN ? writeAge + 1 : 0;

   always @(posedge CLK)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycleLimit);
         abortRun();
      end
   end

   assert property (@(posedge CLK) disable iff (!nRST)
      (dhit && dmemREN) |-> (dmemload == shadow[dmemaddr[7:2]]))
      else reportError($sformatf("read %h returned %h", dmemaddr, dmemload));

   assert property (@(posedge CLK) disable iff (!nRST)
      (dmemWEN && rehit) |-> (dhit == (writeAge == 2)))
      else reportError($sformatf("write hit to %h done at wrong cycle", dmemaddr));

   // write-back data must be the newest value
   assert property (@(posedge CLK) disable iff (!nRST)
      (dWEN && !dwait) |-> (dstore == shadow[daddr[7:2]]))
      else reportError($sformatf("write-back to %h carried %h", daddr, dstore));

   assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
      else reportError("dREN and dWEN high together");

   assert property (@(posedge CLK) disable iff (!nRST)
      $past((dREN || dWEN) && dwait) |->
         ($stable(daddr) && $stable(dstore) && $stable(dREN) && $stable(dWEN)))
      else reportError("memory request moved while dwait high");

   assert property (@(posedge CLK) disable iff (!nRST)
      $past(flushed) |-> (flushed && !dREN && !dWEN))
      else reportError("flushed dropped or a strobe followed it");

   initial
   begin
      logic [31:0] kind;
      logic [31:0] data;
      logic [31:0] bits;
      word_t       addr;
      word_t       lastAddr;
      CLK        = 1'b0;
      nRST       = 1'b0;
      dmemREN    = 1'b0;
      dmemWEN    = 1'b0;
      dmemaddr   = '0;
      dmemstore  = '0;
      halt       = 1'b0;
      rehit      = 1'b0;
      latency    = 2'd0;
      writeAge   = 0;
      cycleCount = 0;
      stimState  = 32'h8ca86728;
      waitState  = 32'h8ca86728;
      for (int i = 0; i < 64; i++)
         shadow[i] = word_t'(i << 2) ^ fillKey;
      repeat (4) @(posedge CLK);
      #driveDelay;
      nRST = 1'b1;
      @(posedge CLK);
      #driveDelay;
      // three tags in one set, evicts dirty blocks
      for (int t = 0; t < 3; t++)
      begin
         takeBits(stimState, 32, data);
         runOp(1'b1, addrOf(t, 5, 0), data, 1'b0);
         runOp(1'b0, addrOf(t, 5, 1), '0, 1'b0);
      end
      for (int t = 0; t < 3; t++)
         runOp(1'b0, addrOf(t, 5, 0), '0, 1'b0);
      lastAddr = addrOf(2, 5, 0);
      for (int n = 0; n < randomOps; n++)
      begin
         takeBits(stimState, 2, kind);
         takeBits(stimState, 32, data);
         takeBits(stimState, 6, bits);
         addr = {24'b0, bits[5:0], 2'b00};
         if (kind == 0)
            runOp(1'b1, lastAddr, data, 1'b1);
         else
         begin
            runOp(kind == 1, addr, data, 1'b0);
            lastAddr = addr;
         end
      end
      halt = 1'b1;
      do
         @(negedge CLK);
      while (!flushed);
      repeat (4) @(posedge CLK);
      for (int i = 0; i < 64; i++)
         assert (i_mem.mem[i] == shadow[i])
            else reportError($sformatf("memory word %0d holds %h after flush", i, i_mem.mem[i]));
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

// File: dcache.f
dcachePkg.sv
dcacheLookup.sv
dcacheStore.sv
dcacheControl.sv
dcache.sv
dcacheMemModel.sv
dcacheTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module dcacheTb \
      -f dcache.f -o simDcache; then
   echo "build failed"
   exit 1
fi

output="$(./obj_dir/simDcache)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx '\*\* PASS \*\*' <<< "$output"; then
   exit 0
fi
exit 1
